/* aluExecute.sv */
`timescale 1ns/100ps
`include "rvCore_config.svh"

module aluExecute (
  input  logic              clk,
  input  logic              rstN,
  input  rvCorePkg::decodeS decoded,
  output rvCorePkg::execS   executed
);

  rvCorePkg::xlenT opA;
  rvCorePkg::xlenT opB;
  rvCorePkg::xlenT res;
  logic [31:0] word; // word-form result before sign extension
  rvCorePkg::execS execNext;

  always_comb begin
    opA = decoded.srcAIsPc ? decoded.pc : decoded.rs1Data;
    case (decoded.srcBSel)
      `SRCB_IMM:  opB = decoded.imm;
      `SRCB_FOUR: opB = `XLEN'd4; // link offset
      default:    opB = decoded.rs2Data;
    endcase
  end

  always_comb begin
    res  = '0;
    word = '0;
    case (decoded.aluOp)
      `ALU_ADD:   res = opA + opB;
      `ALU_SUB:   res = opA - opB;
      `ALU_SLL:   res = opA << opB[5:0]; // 6-bit shamt
      `ALU_SRL:   res = opA >> opB[5:0];
      `ALU_SRA:   res = $signed(opA) >>> opB[5:0];
      `ALU_SLT:   res = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
      `ALU_SLTU:  res = {{(`XLEN-1){1'b0}}, opA < opB};
      `ALU_XOR:   res = opA ^ opB;
      `ALU_OR:    res = opA | opB;
      `ALU_AND:   res = opA & opB;
      `ALU_COPYB: res = opB;
      (`ALU_ADD | `ALU_WORD): word = opA[31:0] + opB[31:0];
      (`ALU_SUB | `ALU_WORD): word = opA[31:0] - opB[31:0];
      (`ALU_SLL | `ALU_WORD): word = opA[31:0] << opB[4:0]; // 5-bit shamt
      (`ALU_SRL | `ALU_WORD): word = opA[31:0] >> opB[4:0];
      (`ALU_SRA | `ALU_WORD): word = $signed(opA[31:0]) >>> opB[4:0];
      default:    res = '0;
    endcase
    if (decoded.aluOp[4]) begin
      res = {{(`XLEN-32){word[31]}}, word}; // sign extend word forms
    end
  end

  always_comb begin
    execNext           = '0;
    execNext.valid     = decoded.valid;
    execNext.illegal   = decoded.illegal;
    execNext.branchOp  = decoded.branchOp;
    execNext.rdWen     = decoded.rdWen;
    execNext.rdAddr    = decoded.rdAddr;
    execNext.pc        = decoded.pc;
    execNext.rs1Data   = decoded.rs1Data; // jalr base
    execNext.imm       = decoded.imm;
    execNext.aluResult = res;
    execNext.equal     = (decoded.rs1Data == decoded.rs2Data); // beq / bne
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      executed <= '0;
    end else begin
      executed <= execNext;
    end
  end

  // decoder only marks add, sub and shifts as word forms
  assert property (@(posedge clk) disable iff (!rstN)
    decoded.valid && !decoded.illegal && decoded.aluOp[4] |->
      !(decoded.aluOp[3:0] inside {`ALU_SLT & 5'h0f, `ALU_SLTU & 5'h0f, `ALU_XOR & 5'h0f,
                                   `ALU_OR & 5'h0f, `ALU_AND & 5'h0f}));

endmodule

/* compile.f */
+incdir+.
rvCorePkg.sv
instrDecoder.sv
aluExecute.sv
writebackStage.sv
rvExecCore.sv
tbClockGen.sv
rvExecCoreTb.sv

/* instrDecoder.sv */
`timescale 1ns/100ps
`include "rvCore_config.svh"

module instrDecoder (
  input  logic               clk,
  input  logic               rstN,
  input  logic               instrValid, // one-cycle strobe
  input  rvCorePkg::instrT   instr,
  input  rvCorePkg::xlenT    pc,
  input  rvCorePkg::xlenT    rs1Data,
  input  rvCorePkg::xlenT    rs2Data,
  output rvCorePkg::decodeS  decoded
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic shiftAlt;   // srai / sraiw select
  logic rTypeOk;    // funct7 is base or alternate form
  rvCorePkg::xlenT immI;
  rvCorePkg::xlenT immU;
  rvCorePkg::xlenT immB;
  rvCorePkg::xlenT immJ;
  rvCorePkg::xlenT imm;
  rvCorePkg::aluOpT aluOp;
  rvCorePkg::srcBSelT srcBSel;
  rvCorePkg::branchOpT branchOp;
  logic srcAIsPc;
  logic wen;
  logic legal;
  rvCorePkg::decodeS decNext;

  // funct3 to base alu code, alt picks sub / sra
  function automatic rvCorePkg::aluOpT f3ToAlu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  f3ToAlu = alt ? `ALU_SUB : `ALU_ADD;
      3'b001:  f3ToAlu = `ALU_SLL;
      3'b010:  f3ToAlu = `ALU_SLT;
      3'b011:  f3ToAlu = `ALU_SLTU;
      3'b100:  f3ToAlu = `ALU_XOR;
      3'b101:  f3ToAlu = alt ? `ALU_SRA : `ALU_SRL;
      3'b110:  f3ToAlu = `ALU_OR;
      default: f3ToAlu = `ALU_AND;
    endcase
  endfunction

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign shiftAlt = instr[30] & (funct3 == 3'b101); // addi keeps bit 30 as imm
  assign rTypeOk  = (funct7 == 7'b0000000) ||
                    ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));

  assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
  assign immU = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
  assign immB = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immJ = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    aluOp    = `ALU_ADD;
    srcAIsPc = 1'b0;
    srcBSel  = `SRCB_RS2;
    branchOp = `BR_NONE;
    imm      = immI;
    wen      = 1'b0;
    legal    = 1'b0; // anything not listed is illegal
    case (opcode)
      7'b0110111: begin // lui
        aluOp   = `ALU_COPYB;
        srcBSel = `SRCB_IMM;
        imm     = immU;
        wen     = 1'b1;
        legal   = 1'b1;
      end
      7'b0010111: begin // auipc
        srcAIsPc = 1'b1;
        srcBSel  = `SRCB_IMM;
        imm      = immU;
        wen      = 1'b1;
        legal    = 1'b1;
      end
      7'b1101111: begin // jal, alu makes the link
        srcAIsPc = 1'b1;
        srcBSel  = `SRCB_FOUR;
        branchOp = `BR_JAL;
        imm      = immJ;
        wen      = 1'b1;
        legal    = 1'b1;
      end
      7'b1100111: begin // jalr
        srcAIsPc = 1'b1;
        srcBSel  = `SRCB_FOUR;
        branchOp = `BR_JALR;
        wen      = 1'b1;
        legal    = (funct3 == 3'b000);
      end
      7'b0010011: begin // op-imm
        aluOp   = f3ToAlu(funct3, shiftAlt);
        srcBSel = `SRCB_IMM;
        wen     = 1'b1;
        case (funct3)
          3'b001:  legal = (instr[31:26] == 6'b000000); // 6-bit shamt
          3'b101:  legal = (instr[31:26] == 6'b000000) || (instr[31:26] == 6'b010000);
          default: legal = 1'b1;
        endcase
      end
      7'b0110011: begin // op, mul/div falls out via rTypeOk
        aluOp = f3ToAlu(funct3, funct7[5]);
        wen   = 1'b1;
        legal = rTypeOk;
      end
      7'b0011011: begin // op-imm-32
        aluOp   = f3ToAlu(funct3, shiftAlt) | `ALU_WORD;
        srcBSel = `SRCB_IMM;
        wen     = 1'b1;
        case (funct3)
          3'b000:  legal = 1'b1; // addiw
          3'b001:  legal = (funct7 == 7'b0000000);
          3'b101:  legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          default: legal = 1'b0;
        endcase
      end
      7'b0111011: begin // op-32
        aluOp = f3ToAlu(funct3, funct7[5]) | `ALU_WORD;
        wen   = 1'b1;
        legal = rTypeOk && ((funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101));
      end
      7'b1100011: begin // branches, compare in alu
        aluOp = funct3[1] ? `ALU_SLTU : `ALU_SLT;
        imm   = immB;
        legal = 1'b1;
        case (funct3)
          3'b000:          branchOp = `BR_EQ;
          3'b001:          branchOp = `BR_NE;
          3'b100, 3'b110:  branchOp = `BR_LT;
          3'b101, 3'b111:  branchOp = `BR_GE;
          default:         legal = 1'b0;
        endcase
      end
      default: legal = 1'b0; // loads, stores, system, fence
    endcase
  end

  always_comb begin
    decNext          = '0;
    decNext.valid    = instrValid;
    decNext.illegal  = instrValid & ~legal;
    decNext.aluOp    = aluOp;
    decNext.srcAIsPc = srcAIsPc;
    decNext.srcBSel  = srcBSel;
    decNext.branchOp = legal ? branchOp : `BR_NONE; // illegal never redirects
    decNext.rdWen    = instrValid & legal & wen & (instr[11:7] != 5'd0); // x0 stays 0
    decNext.rdAddr   = instr[11:7];
    decNext.pc       = pc;
    decNext.rs1Data  = rs1Data;
    decNext.rs2Data  = rs2Data;
    decNext.imm      = imm;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      decoded <= '0;
    end else begin
      decoded <= decNext;
    end
  end

  // conditional branches never write rd
  assert property (@(posedge clk) disable iff (!rstN)
    decoded.valid && !decoded.illegal |-> !(decoded.rdWen && decoded.branchOp[2]));

endmodule

/* run.sh */
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rvExecCoreTb -f compile.f \
  && ./obj_dir/VrvExecCoreTb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* rvCorePkg.sv */
`include "rvCore_config.svh"

package rvCorePkg;

  typedef logic [`XLEN-1:0] xlenT; // data word
  typedef logic [31:0] instrT;
  typedef logic [4:0] regAddrT;
  typedef logic [4:0] aluOpT;      // see ALU_* codes
  typedef logic [2:0] branchOpT;   // see BR_* codes
  typedef logic [1:0] srcBSelT;    // see SRCB_* codes

  // decode -> execute
  typedef struct packed {
    logic     valid;    // only qualifier of the stage
    logic     illegal;  // dropped or malformed encoding
    aluOpT    aluOp;
    logic     srcAIsPc; // 1: pc, 0: rs1
    srcBSelT  srcBSel;  // rs2, imm or 4
    branchOpT branchOp;
    logic     rdWen;    // already 0 for x0 and illegal
    regAddrT  rdAddr;
    xlenT     pc;
    xlenT     rs1Data;
    xlenT     rs2Data;
    xlenT     imm;      // I, U, B or J, sign extended
  } decodeS;

  // execute -> writeback
  typedef struct packed {
    logic     valid;
    logic     illegal;
    branchOpT branchOp;
    logic     rdWen;
    regAddrT  rdAddr;
    xlenT     pc;
    xlenT     rs1Data;   // jalr base
    xlenT     imm;       // branch / jump offset
    xlenT     aluResult; // rd value, or compare bit for blt/bge
    logic     equal;     // rs1 == rs2
  } execS;

endpackage

/* rvCore_config.svh */
`ifndef RVCORE_CONFIG_SVH
`define RVCORE_CONFIG_SVH

`define XLEN 64 // data width

// alu operation codes
`define ALU_ADD   5'b00000
`define ALU_SLL   5'b00001
`define ALU_SLT   5'b00010
`define ALU_SLTU  5'b00011
`define ALU_XOR   5'b00100
`define ALU_SRL   5'b00101
`define ALU_OR    5'b00110
`define ALU_AND   5'b00111
`define ALU_SUB   5'b01000
`define ALU_SRA   5'b01101
`define ALU_COPYB 5'b01111 // passes operand b for lui
`define ALU_WORD  5'b10000 // bit 4 marks the rv64 word form

`define BR_NONE 3'b000
`define BR_JAL  3'b001
`define BR_JALR 3'b010
`define BR_EQ   3'b100 // conditional codes all have bit 2 set
`define BR_NE   3'b101
`define BR_LT   3'b110 // taken on alu bit 0
`define BR_GE   3'b111 // taken on !alu bit 0

`define SRCB_RS2  2'd0
`define SRCB_IMM  2'd1
`define SRCB_FOUR 2'd2 // link value pc + 4

`define PIPE_DEPTH 3 // decode, execute, writeback

`endif

/* rvExecCore.sv */
`timescale 1ns/100ps
`include "rvCore_config.svh"

module rvExecCore (
  input  logic               clk,
  input  logic               rstN,
  input  logic               instrValid,
  input  rvCorePkg::instrT   instr,
  input  rvCorePkg::xlenT    pc,
  input  rvCorePkg::xlenT    rs1Data,
  input  rvCorePkg::xlenT    rs2Data,
  output logic               resultValid,
  output logic               rdWen,
  output rvCorePkg::regAddrT rdAddr,
  output rvCorePkg::xlenT    rdData,
  output logic               redirect,
  output rvCorePkg::xlenT    nextPc,
  output logic               illegal
);

  rvCorePkg::decodeS decoded;  // stage 1 -> 2
  rvCorePkg::execS   executed; // stage 2 -> 3

  instrDecoder i_instrDecoder (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .pc         (pc),
    .rs1Data    (rs1Data),
    .rs2Data    (rs2Data),
    .decoded    (decoded)
  );

  aluExecute i_aluExecute (
    .clk      (clk),
    .rstN     (rstN),
    .decoded  (decoded),
    .executed (executed)
  );

  writebackStage i_writebackStage (
    .clk         (clk),
    .rstN        (rstN),
    .executed    (executed),
    .resultValid (resultValid),
    .rdWen       (rdWen),
    .rdAddr      (rdAddr),
    .rdData      (rdData),
    .redirect    (redirect),
    .nextPc      (nextPc),
    .illegal     (illegal)
  );

endmodule

/* rvExecCoreTb.sv */
`timescale 1ns/100ps
`include "rvCore_config.svh"

module rvExecCoreTb;

  localparam int NUM_TESTS      = 6;
  localparam int INSTR_TOTAL    = 15 + 9 + 8 + 18 + 8;   // instructions over all tests
  localparam int TIMEOUT_CYCLES = 4 * INSTR_TOTAL + 16; // plus reset

  // expected retire values, one per issued instruction
  typedef struct packed {
    logic               valid;
    logic               illegal;
    logic               rdWen;
    logic               redirect;
    rvCorePkg::regAddrT rdAddr;
    rvCorePkg::xlenT    rdData;
    rvCorePkg::xlenT    nextPc;
    logic [2:0]         testId;
  } expS;

  logic clk;
  logic rstN;
  logic instrValid;
  rvCorePkg::instrT instr;
  rvCorePkg::xlenT pc;
  rvCorePkg::xlenT rs1Data;
  rvCorePkg::xlenT rs2Data;
  logic resultValid;
  logic rdWen;
  rvCorePkg::regAddrT rdAddr;
  rvCorePkg::xlenT rdData;
  logic redirect;
  rvCorePkg::xlenT nextPc;
  logic illegal;

  expS expIn;  // goes with the instruction on the inputs
  expS exp1;
  expS exp2;
  expS exp3;   // lines up with the DUT outputs
  logic armed = 1'b0;
  int cycles = 0;
  int errCount = 0;
  int testErr[NUM_TESTS];
  logic [31:0] lfsr = 32'h14f71bc9;

  string testNames[NUM_TESTS] = '{"reset", "aluOps", "wordOps", "upperJump", "branches",
                                  "dropped"};
  string regOps[10] = '{"add", "sub", "slt", "sltu", "xor", "or", "and", "sll", "srl", "sra"};
  string immOps[4]  = '{"addi", "xori", "slli", "srai"};
  string wordOps[5] = '{"addw", "subw", "sllw", "srlw", "sraw"};
  string wordImm[4] = '{"addiw", "slliw", "srliw", "sraiw"};
  string brOps[6]   = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
  string badOps[5]  = '{"lw", "sw", "mul", "ecall", "csrrw"};

  tbClockGen i_tbClockGen (
    .clk (clk)
  );

  rvExecCore i_rvExecCore (
    .clk         (clk),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .instr       (instr),
    .pc          (pc),
    .rs1Data     (rs1Data),
    .rs2Data     (rs2Data),
    .resultValid (resultValid),
    .rdWen       (rdWen),
    .rdAddr      (rdAddr),
    .rdData      (rdData),
    .redirect    (redirect),
    .nextPc      (nextPc),
    .illegal     (illegal)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    lfsrNext = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic rvCorePkg::xlenT takeBits(input int n);
    rvCorePkg::xlenT v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr); // one step per bit
      v = {v[62:0], lfsr[0]};
    end
    takeBits = v;
  endfunction

  function automatic rvCorePkg::xlenT signExt(input rvCorePkg::xlenT v, input int bits);
    rvCorePkg::xlenT up;
    up = v << (64 - bits);
    signExt = $signed(up) >>> (64 - bits);
  endfunction

  function automatic rvCorePkg::xlenT sext32(input logic [31:0] w);
    sext32 = {{32{w[31]}}, w};
  endfunction

  function automatic rvCorePkg::regAddrT randRd();
    randRd = 5'(takeBits(5)) | 5'd1; // never x0
  endfunction

  // rs1 is x1, rs2 is x2; only the data ports carry values
  function automatic rvCorePkg::instrT encode(input string op, input rvCorePkg::regAddrT rd,
                                              input rvCorePkg::xlenT imm);
    case (op)
      "add":   encode = {7'h00, 5'd2, 5'd1, 3'd0, rd, 7'h33};
      "sub":   encode = {7'h20, 5'd2, 5'd1, 3'd0, rd, 7'h33};
      "sll":   encode = {7'h00, 5'd2, 5'd1, 3'd1, rd, 7'h33};
      "slt":   encode = {7'h00, 5'd2, 5'd1, 3'd2, rd, 7'h33};
      "sltu":  encode = {7'h00, 5'd2, 5'd1, 3'd3, rd, 7'h33};
      "xor":   encode = {7'h00, 5'd2, 5'd1, 3'd4, rd, 7'h33};
      "srl":   encode = {7'h00, 5'd2, 5'd1, 3'd5, rd, 7'h33};
      "sra":   encode = {7'h20, 5'd2, 5'd1, 3'd5, rd, 7'h33};
      "or":    encode = {7'h00, 5'd2, 5'd1, 3'd6, rd, 7'h33};
      "and":   encode = {7'h00, 5'd2, 5'd1, 3'd7, rd, 7'h33};
      "mul":   encode = {7'h01, 5'd2, 5'd1, 3'd0, rd, 7'h33};
      "addi":  encode = {imm[11:0], 5'd1, 3'd0, rd, 7'h13};
      "xori":  encode = {imm[11:0], 5'd1, 3'd4, rd, 7'h13};
      "slli":  encode = {6'h00, imm[5:0], 5'd1, 3'd1, rd, 7'h13}; // 6-bit shamt
      "srai":  encode = {6'h10, imm[5:0], 5'd1, 3'd5, rd, 7'h13};
      "addiw": encode = {imm[11:0], 5'd1, 3'd0, rd, 7'h1b};
      "slliw": encode = {7'h00, imm[4:0], 5'd1, 3'd1, rd, 7'h1b};
      "srliw": encode = {7'h00, imm[4:0], 5'd1, 3'd5, rd, 7'h1b};
      "sraiw": encode = {7'h20, imm[4:0], 5'd1, 3'd5, rd, 7'h1b};
      "addw":  encode = {7'h00, 5'd2, 5'd1, 3'd0, rd, 7'h3b};
      "subw":  encode = {7'h20, 5'd2, 5'd1, 3'd0, rd, 7'h3b};
      "sllw":  encode = {7'h00, 5'd2, 5'd1, 3'd1, rd, 7'h3b};
      "srlw":  encode = {7'h00, 5'd2, 5'd1, 3'd5, rd, 7'h3b};
      "sraw":  encode = {7'h20, 5'd2, 5'd1, 3'd5, rd, 7'h3b};
      "lui":   encode = {imm[31:12], rd, 7'h37};
      "auipc": encode = {imm[31:12], rd, 7'h17};
      "jal":   encode = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
      "jalr":  encode = {imm[11:0], 5'd1, 3'd0, rd, 7'h67};
      "beq":   encode = {imm[12], imm[10:5], 5'd2, 5'd1, 3'd0, imm[4:1], imm[11], 7'h63};
      "bne":   encode = {imm[12], imm[10:5], 5'd2, 5'd1, 3'd1, imm[4:1], imm[11], 7'h63};
      "blt":   encode = {imm[12], imm[10:5], 5'd2, 5'd1, 3'd4, imm[4:1], imm[11], 7'h63};
      "bge":   encode = {imm[12], imm[10:5], 5'd2, 5'd1, 3'd5, imm[4:1], imm[11], 7'h63};
      "bltu":  encode = {imm[12], imm[10:5], 5'd2, 5'd1, 3'd6, imm[4:1], imm[11], 7'h63};
      "bgeu":  encode = {imm[12], imm[10:5], 5'd2, 5'd1, 3'd7, imm[4:1], imm[11], 7'h63};
      "lw":    encode = {imm[11:0], 5'd1, 3'd2, rd, 7'h03};
      "sw":    encode = {imm[11:5], 5'd2, 5'd1, 3'd2, imm[4:0], 7'h23};
      "ecall": encode = 32'h0000_0073;
      "csrrw": encode = {12'h300, 5'd1, 3'd1, rd, 7'h73};
      default: encode = 32'h0;
    endcase
  endfunction

  // ISA-level result; b is rs2 or the immediate as the caller chose
  function automatic expS model(input string op, input rvCorePkg::regAddrT rd,
                                input rvCorePkg::xlenT pcV, input rvCorePkg::xlenT a,
                                input rvCorePkg::xlenT b, input rvCorePkg::xlenT imm);
    expS e;
    logic taken;
    e = '0;
    taken = 1'b0;
    e.valid = 1'b1;
    e.rdAddr = rd;
    e.rdWen = (rd != 5'd0); // x0 never written
    e.nextPc = pcV + 64'd4;
    case (op)
      "add", "addi":   e.rdData = a + b;
      "sub":           e.rdData = a - b;
      "sll", "slli":   e.rdData = a << b[5:0];
      "srl":           e.rdData = a >> b[5:0];
      "sra", "srai":   e.rdData = $signed(a) >>> b[5:0];
      "slt":           e.rdData = {63'd0, $signed(a) < $signed(b)};
      "sltu":          e.rdData = {63'd0, a < b};
      "xor", "xori":   e.rdData = a ^ b;
      "or":            e.rdData = a | b;
      "and":           e.rdData = a & b;
      "addw", "addiw": e.rdData = sext32(a[31:0] + b[31:0]);
      "subw":          e.rdData = sext32(a[31:0] - b[31:0]);
      "sllw", "slliw": e.rdData = sext32(a[31:0] << b[4:0]);
      "srlw", "srliw": e.rdData = sext32(a[31:0] >> b[4:0]);
      "sraw", "sraiw": e.rdData = sext32($signed(a[31:0]) >>> b[4:0]);
      "lui":           e.rdData = imm;
      "auipc":         e.rdData = pcV + imm;
      "jal": begin
        e.rdData = pcV + 64'd4; // link
        taken = 1'b1;
        e.nextPc = pcV + imm;
      end
      "jalr": begin
        e.rdData = pcV + 64'd4;
        taken = 1'b1;
        e.nextPc = (a + imm) & ~64'd1;
      end
      "beq":  taken = (a == b);
      "bne":  taken = (a != b);
      "blt":  taken = ($signed(a) < $signed(b));
      "bge":  taken = ($signed(a) >= $signed(b));
      "bltu": taken = (a < b);
      "bgeu": taken = (a >= b);
      default: begin // loads, stores, mul, system
        e.illegal = 1'b1;
        e.rdWen = 1'b0;
      end
    endcase
    if (op.substr(0, 0) == "b") begin
      e.rdWen = 1'b0; // branches write nothing
      if (taken) begin
        e.nextPc = pcV + imm;
      end
    end
    e.redirect = taken;
    model = e;
  endfunction

  task automatic mismatch(input string field, input rvCorePkg::xlenT expV,
                          input rvCorePkg::xlenT actV, input logic [2:0] id);
    $display("ERROR %s %s expected %h actual %h", testNames[id], field, expV, actV);
    errCount++;
    testErr[id]++;
  endtask

  // called at edge + 2 ns, leaves at the next edge + 2 ns
  task automatic issue(input string op, input rvCorePkg::regAddrT rd,
                       input rvCorePkg::xlenT a, input rvCorePkg::xlenT b,
                       input rvCorePkg::xlenT imm, input int id);
    rvCorePkg::xlenT pcV;
    pcV = takeBits(32) << 2; // word aligned
    instrValid = 1'b1;
    instr = encode(op, rd, imm);
    pc = pcV;
    rs1Data = a;
    rs2Data = b;
    expIn = model(op, rd, pcV, a, b, imm);
    expIn.testId = 3'(id);
    @(posedge clk);
    #2;
    instrValid = 1'b0;
    expIn = '0;
  endtask

  task automatic maybeIdle();
    if (takeBits(1) != 0) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic endTest(input int id, input int count);
    repeat (`PIPE_DEPTH + 1) @(posedge clk); // drain
    #2;
    $display("test %-10s %0d instructions, %0d errors", testNames[id], count, testErr[id]);
  endtask

  always_ff @(posedge clk) begin
    if (!rstN) begin
      exp1 <= '0;
      exp2 <= '0;
      exp3 <= '0;
    end else begin
      exp1 <= expIn;
      exp2 <= exp1;
      exp3 <= exp2;
    end
  end

  always @(posedge clk) begin
    armed <= 1'b1; // outputs are defined after the first reset edge
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, results stopped arriving", cycles);
      $display("Something failed");
      $finish;
    end
  end

  assert property (@(posedge clk) armed |-> resultValid == exp3.valid)
    else mismatch("resultValid", $sampled(exp3.valid), $sampled(resultValid),
                  $sampled(exp3.testId));
  assert property (@(posedge clk) armed && !resultValid |-> !rdWen && !redirect && !illegal)
    else begin
      $display("control outputs high outside a result cycle");
      errCount++;
    end
  assert property (@(posedge clk) resultValid |-> rdWen == exp3.rdWen)
    else mismatch("rdWen", $sampled(exp3.rdWen), $sampled(rdWen), $sampled(exp3.testId));
  assert property (@(posedge clk) resultValid |-> illegal == exp3.illegal)
    else mismatch("illegal", $sampled(exp3.illegal), $sampled(illegal), $sampled(exp3.testId));
  assert property (@(posedge clk) resultValid |-> redirect == exp3.redirect)
    else mismatch("redirect", $sampled(exp3.redirect), $sampled(redirect),
                  $sampled(exp3.testId));
  assert property (@(posedge clk) resultValid |-> nextPc == exp3.nextPc)
    else mismatch("nextPc", $sampled(exp3.nextPc), $sampled(nextPc), $sampled(exp3.testId));
  assert property (@(posedge clk) resultValid && exp3.rdWen |-> rdAddr == exp3.rdAddr)
    else mismatch("rdAddr", $sampled(exp3.rdAddr), $sampled(rdAddr), $sampled(exp3.testId));
  assert property (@(posedge clk) resultValid && exp3.rdWen |-> rdData == exp3.rdData)
    else mismatch("rdData", $sampled(exp3.rdData), $sampled(rdData), $sampled(exp3.testId));

  initial begin
    rvCorePkg::xlenT a;
    rvCorePkg::xlenT b;
    rvCorePkg::xlenT imm;
    rstN = 1'b0;
    instrValid = 1'b0;
    instr = '0;
    pc = '0;
    rs1Data = '0;
    rs2Data = '0;
    expIn = '0;
    repeat (16) @(posedge clk);
    #2;
    rstN = 1'b1;
    endTest(0, 0); // outputs stay low while idle

    foreach (regOps[k]) begin
      issue(regOps[k], randRd(), takeBits(64), takeBits(64), '0, 1);
      maybeIdle();
    end
    foreach (immOps[k]) begin
      imm = (k < 2) ? signExt(takeBits(12), 12) : takeBits(6);
      issue(immOps[k], randRd(), takeBits(64), imm, imm, 1);
      maybeIdle();
    end
    issue("add", 5'd0, takeBits(64), takeBits(64), '0, 1); // write to x0
    endTest(1, 15);

    foreach (wordOps[k]) begin
      issue(wordOps[k], randRd(), takeBits(64), takeBits(64), '0, 2);
      maybeIdle();
    end
    foreach (wordImm[k]) begin
      imm = (k == 0) ? signExt(takeBits(12), 12) : takeBits(5);
      issue(wordImm[k], randRd(), takeBits(64), imm, imm, 2);
      maybeIdle();
    end
    endTest(2, 9);

    for (int r = 0; r < 2; r++) begin
      issue("lui", randRd(), takeBits(64), takeBits(64), signExt(takeBits(20) << 12, 32), 3);
      issue("auipc", randRd(), takeBits(64), takeBits(64), signExt(takeBits(20) << 12, 32), 3);
      issue("jal", randRd(), takeBits(64), takeBits(64), signExt(takeBits(20) << 1, 21), 3);
      issue("jalr", randRd(), takeBits(64), takeBits(64), signExt(takeBits(12), 12), 3);
      maybeIdle();
    end
    endTest(3, 8);

    // equal, sign boundary, unsigned boundary
    for (int p = 0; p < 3; p++) begin
      foreach (brOps[k]) begin
        a = (p == 1) ? '1 : (p == 2) ? 64'h7fff_ffff_ffff_ffff : takeBits(64);
        b = (p == 1) ? '0 : (p == 2) ? 64'h8000_0000_0000_0000 : a;
        issue(brOps[k], randRd(), a, b, signExt(takeBits(12) << 1, 13), 4);
        maybeIdle();
      end
    end
    endTest(4, 18);

    foreach (badOps[k]) begin
      issue(badOps[k], randRd(), takeBits(64), takeBits(64), signExt(takeBits(12), 12), 5);
      maybeIdle();
    end
    issue("add", randRd(), takeBits(64), takeBits(64), '0, 5); // three back to back
    issue("jal", randRd(), takeBits(64), takeBits(64), signExt(takeBits(20) << 1, 21), 5);
    issue("bne", randRd(), takeBits(64), takeBits(64), signExt(takeBits(12) << 1, 13), 5);
    endTest(5, 8);

    $display("%0d tests, %0d instructions, %0d checks failed", NUM_TESTS, INSTR_TOTAL,
             errCount);
    if (errCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* tbClockGen.sv */
`timescale 1ns/100ps

module tbClockGen #(
  parameter int HALF_PERIOD = 10 // 20 ns clock
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(HALF_PERIOD) clk = ~clk;

endmodule

/* writebackStage.sv */
`timescale 1ns/100ps
`include "rvCore_config.svh"

module writebackStage (
  input  logic              clk,
  input  logic              rstN,
  input  rvCorePkg::execS   executed,
  output logic              resultValid, // one-cycle strobe
  output logic              rdWen,
  output rvCorePkg::regAddrT rdAddr,
  output rvCorePkg::xlenT   rdData,
  output logic              redirect,    // jump or taken branch
  output rvCorePkg::xlenT   nextPc,
  output logic              illegal
);

  rvCorePkg::xlenT seqPc;
  rvCorePkg::xlenT pcTarget;   // pc + imm
  rvCorePkg::xlenT jalrSum;
  rvCorePkg::xlenT pcNext;
  logic taken;

  assign seqPc    = executed.pc + `XLEN'd4;
  assign pcTarget = executed.pc + executed.imm;
  assign jalrSum  = executed.rs1Data + executed.imm;

  always_comb begin
    taken  = 1'b0;
    pcNext = seqPc;
    case (executed.branchOp)
      `BR_JAL: begin
        taken  = 1'b1;
        pcNext = pcTarget;
      end
      `BR_JALR: begin
        taken  = 1'b1;
        pcNext = {jalrSum[`XLEN-1:1], 1'b0}; // bit 0 cleared
      end
      `BR_EQ: taken = executed.equal;
      `BR_NE: taken = ~executed.equal;
      `BR_LT: taken = executed.aluResult[0];  // slt / sltu bit
      `BR_GE: taken = ~executed.aluResult[0];
      default: taken = 1'b0;
    endcase
    if (taken && executed.branchOp[2]) begin
      pcNext = pcTarget; // taken conditional branch
    end
  end

  // control outputs
  always_ff @(posedge clk) begin
    if (!rstN) begin
      resultValid <= 1'b0;
      rdWen       <= 1'b0;
      redirect    <= 1'b0;
      illegal     <= 1'b0;
    end else begin
      resultValid <= executed.valid;
      rdWen       <= executed.valid & executed.rdWen;
      redirect    <= executed.valid & ~executed.illegal & taken;
      illegal     <= executed.valid & executed.illegal;
    end
  end

  // payload, only meaningful with resultValid
  always_ff @(posedge clk) begin
    rdAddr <= executed.rdAddr;
    rdData <= executed.aluResult; // link value for jumps
    nextPc <= pcNext;
  end

  // illegal encodings must retire with no side effect
  assert property (@(posedge clk) disable iff (!rstN)
    illegal |-> !rdWen && !redirect);

endmodule
